/* design/cmac_dual_group.sv */
`timescale 1ns/1ps

module cmac_dual_group (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  cmac_reg_pkg::reg_bus_t   reg_bus,
  output cmac_reg_pkg::reg_data_t  rd_data,
  input  logic                     done_clear,
  output logic                     op_en,
  output logic                     conv_mode,
  output cmac_reg_pkg::precision_t proc_precision
);
  import cmac_reg_pkg::*;

  logic op_en_wr; // op_enable write strobe
  logic cfg_wr;   // misc_cfg write strobe

  assign op_en_wr = reg_bus.wr_en & (reg_bus.offset == op_enable_offset);
  assign cfg_wr   = reg_bus.wr_en & (reg_bus.offset == misc_cfg_offset);

  ////////////////////
  // config fields
  ////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      conv_mode      <= 1'b0;
      proc_precision <= '0;
    end else if (cfg_wr) begin
      conv_mode      <= reg_bus.wr_data[0];
      proc_precision <= reg_bus.wr_data[13:12];
    end
  end

  // op_en: set by sw, cleared when the datapath finishes this group
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en <= 1'b0;
    end else if (op_en_wr) begin
      op_en <= reg_bus.wr_data[0]; // write only gets through while op_en is low
    end else if (done_clear) begin
      op_en <= 1'b0;
    end
  end

  always_comb begin
    rd_data = '0;
    case (reg_bus.offset)
      op_enable_offset: rd_data[0] = op_en;
      misc_cfg_offset: begin
        rd_data[0]     = conv_mode;
        rd_data[13:12] = proc_precision;
      end
      default: rd_data = '0; // not ours or unmapped
    endcase
  end

  // done may only retire a group that was actually launched
  a_done_on_enabled : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    done_clear |-> op_en)
    else $error("done arrived for a group whose op_en is low");

endmodule

/* design/cmac_group_ctrl.sv */
`timescale 1ns/1ps

module cmac_group_ctrl (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  cmac_reg_pkg::reg_bus_t        reg_bus,
  input  logic                          rd_en,
  output cmac_reg_pkg::reg_data_t       rd_data,
  output cmac_reg_pkg::reg_bus_t        s_bus,
  output cmac_reg_pkg::reg_bus_t        d0_bus,
  output cmac_reg_pkg::reg_bus_t        d1_bus,
  input  cmac_reg_pkg::reg_data_t       s_rd_data,
  input  cmac_reg_pkg::reg_data_t       d0_rd_data,
  input  cmac_reg_pkg::reg_data_t       d1_rd_data,
  input  logic                          producer,
  output logic                          consumer,
  output cmac_reg_pkg::group_status_e   status_0,
  output cmac_reg_pkg::group_status_e   status_1,
  input  logic                          d0_op_en,
  input  logic                          d1_op_en,
  output logic                          d0_done_clear,
  output logic                          d1_done_clear,
  input  logic                          d0_conv_mode,
  input  logic                          d1_conv_mode,
  input  cmac_reg_pkg::precision_t      d0_proc_precision,
  input  cmac_reg_pkg::precision_t      d1_proc_precision,
  input  logic                          dp2reg_done,
  output logic                          reg2dp_op_en,
  output logic                          reg2dp_conv_mode,
  output cmac_reg_pkg::precision_t      reg2dp_proc_precision,
  output logic [cmac_reg_pkg::slcg_num-1:0] slcg_op_en
);
  import cmac_reg_pkg::*;

  logic select_s;  // offset in single group
  logic select_d0; // dual group 0 via producer
  logic select_d1;
  logic op_en_ori; // consumer group's op_en
  logic [op_en_delay-1:0]               op_en_pipe;
  logic [op_en_delay-1:0][slcg_num-1:0] slcg_pipe;

  ////////////////////
  // consumer pointer
  ////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (dp2reg_done) begin
      consumer <= ~consumer; // datapath moves to the other group
    end
  end

  // idle / running (is consumer) / pending (waits behind the other)
  assign status_0 = !d0_op_en ? status_idle :
                    consumer  ? status_pending : status_running;
  assign status_1 = !d1_op_en ? status_idle :
                    !consumer ? status_pending : status_running;

  assign d0_done_clear = dp2reg_done & ~consumer;
  assign d1_done_clear = dp2reg_done & consumer;

  ////////////////////
  // group decode
  ////////////////////
  assign select_s  = (reg_bus.offset < dual_base);
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;

  always_comb begin
    s_bus        = reg_bus;
    s_bus.wr_en  = reg_bus.wr_en & select_s;
    d0_bus       = reg_bus;
    d0_bus.wr_en = reg_bus.wr_en & select_d0 & ~d0_op_en; // locked while enabled
    d1_bus       = reg_bus;
    d1_bus.wr_en = reg_bus.wr_en & select_d1 & ~d1_op_en;
  end

  // one hot select, so OR is enough
  assign rd_data = {32{rd_en}} & (({32{select_s}}  & s_rd_data)  |
                                  ({32{select_d0}} & d0_rd_data) |
                                  ({32{select_d1}} & d1_rd_data));

  ////////////////////
  // datapath outputs
  ////////////////////
  assign reg2dp_conv_mode      = consumer ? d1_conv_mode : d0_conv_mode;
  assign reg2dp_proc_precision = consumer ? d1_proc_precision : d0_proc_precision;
  assign op_en_ori             = consumer ? d1_op_en : d0_op_en;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
      slcg_pipe  <= '0;
    end else begin
      if (dp2reg_done) begin
        op_en_pipe <= '0; // restart delay for next group
      end else begin
        op_en_pipe <= {op_en_pipe[op_en_delay-2:0], op_en_ori};
      end
      slcg_pipe <= {slcg_pipe[op_en_delay-2:0], {slcg_num{op_en_ori}}}; // free running
    end
  end

  assign reg2dp_op_en = op_en_pipe[op_en_delay-1];
  assign slcg_op_en   = slcg_pipe[op_en_delay-1];

  // sw must not touch a dual group while it is enabled
  a_no_locked_write : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(reg_bus.wr_en & ((select_d0 & d0_op_en) | (select_d1 & d1_op_en))))
    else $error("write attempted on a dual group with op_en set");

endmodule

/* design/cmac_reg_pkg.sv */
package cmac_reg_pkg;

  ////////////////////
  // basic types
  ////////////////////
  typedef logic [31:0] reg_data_t;   // register data word
  typedef logic [11:0] reg_offset_t; // byte offset in 4 KB space
  typedef logic [21:0] csb_addr_t;   // word address on csb
  typedef logic [1:0]  precision_t;  // proc precision code

  // per-group status as seen in the status register
  typedef enum logic [1:0] {
    status_idle    = 2'd0,
    status_running = 2'd1, // group is the consumer
    status_pending = 2'd2  // enabled, waiting for its turn
  } group_status_e;

  ////////////////////
  // csb packets
  ////////////////////
  typedef struct packed {
    logic [1:0] level;   // not decoded here
    logic [3:0] wrbe;    // byte enables, full word only
    logic       srcpriv;
    logic       nposted; // write wants a response
    logic       write;
    reg_data_t  wdat;
    csb_addr_t  addr;
  } csb_req_t;

  typedef struct packed {
    logic      is_write; // 1 for write response
    logic      error;    // always 0
    reg_data_t rdat;
  } csb_resp_t;

  // internal register bus, one copy per group
  typedef struct packed {
    reg_offset_t offset;
    reg_data_t   wr_data;
    logic        wr_en;
  } reg_bus_t;

  ////////////////////
  // register map
  ////////////////////
  localparam reg_offset_t pointer_offset   = 12'h000;
  localparam reg_offset_t status_offset    = 12'h004;
  localparam reg_offset_t op_enable_offset = 12'h008;
  localparam reg_offset_t misc_cfg_offset  = 12'h00c;
  localparam reg_offset_t dual_base        = op_enable_offset; // below -> single group

  localparam int op_en_delay = 3; // op_en pipeline depth
  localparam int slcg_num    = 2; // clock gate enables

endpackage

/* design/cmac_reg_top.sv */
`timescale 1ns/1ps

module cmac_reg_top (
  input  logic                              nvdla_core_clk,
  input  logic                              nvdla_core_rstn,
  input  logic                              csb_req_pvld,
  input  cmac_reg_pkg::csb_req_t            csb_req_pd,
  output logic                              csb_req_prdy,
  output logic                              csb_resp_valid,
  output cmac_reg_pkg::csb_resp_t           csb_resp_pd,
  input  logic                              dp2reg_done,
  output logic                              reg2dp_op_en,
  output logic                              reg2dp_conv_mode,
  output cmac_reg_pkg::precision_t          reg2dp_proc_precision,
  output logic [cmac_reg_pkg::slcg_num-1:0] slcg_op_en
);
  import cmac_reg_pkg::*;

  reg_bus_t      reg_bus;                  // from csb port
  reg_bus_t      s_bus, d0_bus, d1_bus;    // gated per group
  reg_data_t     rd_data;
  reg_data_t     s_rd_data, d0_rd_data, d1_rd_data;
  logic          rd_en;
  logic          producer, consumer;
  group_status_e status_0, status_1;
  logic          d0_op_en, d1_op_en;
  logic          d0_done_clear, d1_done_clear;
  logic          d0_conv_mode, d1_conv_mode;
  precision_t    d0_proc_precision, d1_proc_precision;

  csb_req_port u_csb_req_port (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_pvld, .csb_req_pd, .csb_req_prdy,
    .csb_resp_valid, .csb_resp_pd, .reg_bus, .rd_en, .rd_data);

  cmac_single_group u_single_reg (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_bus (s_bus), .rd_data (s_rd_data),
    .producer, .consumer, .status_0, .status_1);

  // ping-pong config groups
  cmac_dual_group u_dual_reg_d0 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_bus (d0_bus), .rd_data (d0_rd_data),
    .done_clear (d0_done_clear), .op_en (d0_op_en), .conv_mode (d0_conv_mode),
    .proc_precision (d0_proc_precision));

  cmac_dual_group u_dual_reg_d1 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_bus (d1_bus), .rd_data (d1_rd_data),
    .done_clear (d1_done_clear), .op_en (d1_op_en), .conv_mode (d1_conv_mode),
    .proc_precision (d1_proc_precision));

  cmac_group_ctrl u_group_ctrl (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_bus, .rd_en, .rd_data,
    .s_bus, .d0_bus, .d1_bus, .s_rd_data, .d0_rd_data, .d1_rd_data,
    .producer, .consumer, .status_0, .status_1,
    .d0_op_en, .d1_op_en, .d0_done_clear, .d1_done_clear,
    .d0_conv_mode, .d1_conv_mode, .d0_proc_precision, .d1_proc_precision,
    .dp2reg_done, .reg2dp_op_en, .reg2dp_conv_mode, .reg2dp_proc_precision,
    .slcg_op_en);

endmodule

/* design/cmac_single_group.sv */
`timescale 1ns/1ps

module cmac_single_group (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  cmac_reg_pkg::reg_bus_t      reg_bus,
  output cmac_reg_pkg::reg_data_t     rd_data,
  output logic                        producer,
  input  logic                        consumer,
  input  cmac_reg_pkg::group_status_e status_0,
  input  cmac_reg_pkg::group_status_e status_1
);
  import cmac_reg_pkg::*;

  logic ptr_wr; // write strobe for pointer register

  assign ptr_wr = reg_bus.wr_en & (reg_bus.offset == pointer_offset);

  // producer pointer, only writable field here
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (ptr_wr) begin
      producer <= reg_bus.wr_data[0];
    end
  end

  ////////////////////
  // read back
  ////////////////////
  always_comb begin
    rd_data = '0; // unmapped reads give zero
    case (reg_bus.offset)
      pointer_offset: begin
        rd_data[0]  = producer;
        rd_data[16] = consumer; // read only
      end
      status_offset: begin
        rd_data[1:0]   = status_0;
        rd_data[17:16] = status_1;
      end
      default: rd_data = '0;
    endcase
  end

endmodule

/* design/csb_req_port.sv */
`timescale 1ns/1ps

module csb_req_port (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic                    csb_req_pvld,
  input  cmac_reg_pkg::csb_req_t  csb_req_pd,
  output logic                    csb_req_prdy,
  output logic                    csb_resp_valid,
  output cmac_reg_pkg::csb_resp_t csb_resp_pd,
  output cmac_reg_pkg::reg_bus_t  reg_bus,
  output logic                    rd_en,
  input  cmac_reg_pkg::reg_data_t rd_data
);
  import cmac_reg_pkg::*;

  logic      req_pvld;   // registered request valid
  csb_req_t  req_pd;     // registered request payload
  logic      wr_en;
  csb_resp_t rresp;      // read response word
  csb_resp_t wresp;      // write ack word

  assign csb_req_prdy = 1'b1; // never back-pressures

  ////////////////////
  // request capture
  ////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb_req_pvld) begin
      req_pd <= csb_req_pd; // hold payload only on valid
    end
  end

  assign wr_en = req_pvld & req_pd.write;
  assign rd_en = req_pvld & ~req_pd.write;

  // csb is word addressed, registers are byte addressed
  assign reg_bus.offset  = {req_pd.addr[9:0], 2'b00};
  assign reg_bus.wr_data = req_pd.wdat;
  assign reg_bus.wr_en   = wr_en;

  ////////////////////
  // response
  ////////////////////
  assign rresp = '{is_write: 1'b0, error: 1'b0, rdat: rd_data};
  assign wresp = '{is_write: 1'b1, error: 1'b0, rdat: '0}; // write ack carries no data

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
      csb_resp_pd    <= '0;
    end else begin
      csb_resp_valid <= rd_en | (wr_en & req_pd.nposted); // posted writes stay silent
      if (rd_en) begin
        csb_resp_pd <= rresp; // data from before this cycle's write
      end else if (wr_en & req_pd.nposted) begin
        csb_resp_pd <= wresp;
      end
    end
  end

  // each response must trace back to a registered request
  a_resp_has_req : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> $past(req_pvld))
    else $error("csb response without a request in the previous cycle");

endmodule

/* sources.f */
design/cmac_reg_pkg.sv
design/csb_req_port.sv
design/cmac_single_group.sv
design/cmac_dual_group.sv
design/cmac_group_ctrl.sv
design/cmac_reg_top.sv
tb/tb_clk_gen.sv
tb/cmac_reg_tb.sv

/* tb/cmac_reg_tb.sv */
`timescale 1ns/1ps

module cmac_reg_tb;
  import cmac_reg_pkg::*;

  logic                nvdla_core_clk, nvdla_core_rstn;
  logic                csb_req_pvld, csb_req_prdy, csb_resp_valid;
  csb_req_t            csb_req_pd;
  csb_resp_t           csb_resp_pd;
  logic                dp2reg_done, reg2dp_op_en, reg2dp_conv_mode;
  precision_t          reg2dp_proc_precision;
  logic [slcg_num-1:0] slcg_op_en;

  integer seed = 32'h36b9;
  int     issued, err_value, err_other; // transactions and error counts
  logic   want_resp;                    // request that needs a response

  // register map model updated when a write lands
  logic                   m_producer, m_consumer;
  logic [1:0]             m_op_en, m_conv_mode;
  precision_t [1:0]       m_prec;
  reg_data_t              exp_rdat;
  logic                   exp_is_write;
  logic [op_en_delay-1:0] exp_op_en_pipe, exp_slcg_pipe;

  tb_clk_gen u_clk_gen (.nvdla_core_clk, .nvdla_core_rstn);

  cmac_reg_top dut (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_pvld, .csb_req_pd, .csb_req_prdy,
    .csb_resp_valid, .csb_resp_pd, .dp2reg_done, .reg2dp_op_en, .reg2dp_conv_mode,
    .reg2dp_proc_precision, .slcg_op_en);

  assign want_resp = csb_req_pvld & (~csb_req_pd.write | csb_req_pd.nposted);

  // expected op_en delay line fed by the consumer group
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      exp_op_en_pipe <= '0;
      exp_slcg_pipe  <= '0;
    end else begin
      exp_slcg_pipe <= {exp_slcg_pipe[op_en_delay-2:0], m_op_en[m_consumer]}; // no clear
      if (dp2reg_done) exp_op_en_pipe <= '0;
      else exp_op_en_pipe <= {exp_op_en_pipe[op_en_delay-2:0], m_op_en[m_consumer]};
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_value++;
    $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  ////////////////////
  // checks
  ////////////////////
  a_resp_timing : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid == $past(want_resp, 2))
    else report_mismatch("csb_resp_valid", $sampled(csb_resp_valid), $past(want_resp, 2));
  a_rdat : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid && !csb_resp_pd.is_write |-> csb_resp_pd.rdat == exp_rdat)
    else report_mismatch("csb_resp_pd.rdat", $sampled(csb_resp_pd.rdat), $sampled(exp_rdat));
  a_is_write : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> csb_resp_pd.is_write == exp_is_write && !csb_resp_pd.error)
    else report_mismatch("csb_resp_pd.is_write/error", $sampled(csb_resp_pd[33:32]),
                         {$sampled(exp_is_write), 1'b0});
  a_prdy : assert property (@(posedge nvdla_core_clk) csb_req_prdy)
    else report_mismatch("csb_req_prdy", $sampled(csb_req_prdy), 1);
  a_op_en : assert property (@(posedge nvdla_core_clk)
    reg2dp_op_en == exp_op_en_pipe[op_en_delay-1])
    else report_mismatch("reg2dp_op_en", $sampled(reg2dp_op_en),
                         $sampled(exp_op_en_pipe[op_en_delay-1]));
  a_slcg : assert property (@(posedge nvdla_core_clk)
    slcg_op_en == {slcg_num{exp_slcg_pipe[op_en_delay-1]}})
    else report_mismatch("slcg_op_en", $sampled(slcg_op_en),
                         {slcg_num{$sampled(exp_slcg_pipe[op_en_delay-1])}});
  a_conv_mode : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_conv_mode == m_conv_mode[m_consumer])
    else report_mismatch("reg2dp_conv_mode", $sampled(reg2dp_conv_mode),
                         $sampled(m_conv_mode[m_consumer]));
  a_precision : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    reg2dp_proc_precision == m_prec[m_consumer])
    else report_mismatch("reg2dp_proc_precision", $sampled(reg2dp_proc_precision),
                         $sampled(m_prec[m_consumer]));

  ////////////////////
  // model helpers
  ////////////////////
  function automatic group_status_e status_of(input logic g);
    if (!m_op_en[g]) return status_idle;
    return (m_consumer == g) ? status_running : status_pending;
  endfunction

  function automatic reg_data_t expected_read(input reg_offset_t offset);
    reg_data_t d;
    d = '0; // unmapped gives zero
    if (offset == pointer_offset) begin
      d[0]  = m_producer;
      d[16] = m_consumer;
    end else if (offset == status_offset) begin
      d[1:0]   = status_of(1'b0);
      d[17:16] = status_of(1'b1);
    end else if (offset == op_enable_offset) begin
      d[0] = m_op_en[m_producer];
    end else if (offset == misc_cfg_offset) begin
      d[0]     = m_conv_mode[m_producer];
      d[13:12] = m_prec[m_producer];
    end
    return d;
  endfunction

  function automatic reg_data_t cfg_word(input logic conv, input precision_t prec);
    reg_data_t w;
    w       = $random(seed); // random padding around the fields
    w[0]    = conv;
    w[13:12] = prec;
    return w;
  endfunction

  ////////////////////
  // csb tasks
  ////////////////////
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge nvdla_core_clk);
      #2;
    end
  endtask

  // one request that returns once it has taken effect
  task automatic send_req(input reg_offset_t offset, input logic write,
                          input logic nposted, input reg_data_t wdat);
    csb_req_t req;
    req         = '0;
    req.level   = $random(seed); // ignored fields get noise
    req.srcpriv = $random(seed);
    req.wrbe    = 4'hf;
    req.nposted = nposted;
    req.write   = write;
    req.wdat    = wdat;
    req.addr    = {12'h000, offset[11:2]};
    csb_req_pvld = 1'b1;
    csb_req_pd   = req;
    issued++;
    wait_cycles(1);
    csb_req_pvld = 1'b0;
    wait_cycles(1);
    while ((!write || nposted) && !csb_resp_valid) wait_cycles(1); // reads and acked writes
  endtask

  task automatic csb_read(input reg_offset_t offset);
    exp_rdat     = expected_read(offset);
    exp_is_write = 1'b0;
    send_req(offset, 1'b0, 1'b0, reg_data_t'($random(seed)));
    wait_cycles(1 + {$random(seed)} % 3);
  endtask

  task automatic csb_write(input reg_offset_t offset, input reg_data_t wdat,
                           input logic nposted);
    exp_is_write = 1'b1;
    send_req(offset, 1'b1, nposted, wdat);
    if (offset == pointer_offset) m_producer = wdat[0];
    else if (!m_op_en[m_producer]) begin // enabled group ignores writes
      if (offset == op_enable_offset) m_op_en[m_producer] = wdat[0];
      if (offset == misc_cfg_offset) begin
        m_conv_mode[m_producer] = wdat[0];
        m_prec[m_producer]      = wdat[13:12];
      end
    end
    wait_cycles(1 + {$random(seed)} % 3);
  endtask

  task automatic pulse_done();
    dp2reg_done = 1'b1;
    issued++;
    wait_cycles(1);
    dp2reg_done = 1'b0;
    m_op_en[m_consumer] = 1'b0; // retire old consumer
    m_consumer          = ~m_consumer;
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 40 * issued + 200) begin
      @(posedge nvdla_core_clk);
      cycles++;
    end
    err_other++;
    $display("timeout: test did not finish within %0d cycles", cycles);
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    csb_req_pvld = 1'b0;
    csb_req_pd   = '0;
    dp2reg_done  = 1'b0;
    m_producer = 1'b0;
    m_consumer = 1'b0;
    m_op_en = '0;
    m_conv_mode = '0;
    m_prec = '0;
    exp_rdat = '0;
    exp_is_write = 1'b0;
    issued = 0;
    err_value = 0;
    err_other = 0;
    @(posedge nvdla_core_rstn);
    wait_cycles(1);
    // reset values, response timing, posted write
    csb_read(pointer_offset);
    csb_read(status_offset);
    csb_write(pointer_offset, reg_data_t'($random(seed)) & ~32'h1, 1'b0);
    csb_read(12'h010);
    csb_read(12'h100);
    // group 0 config
    csb_write(misc_cfg_offset, cfg_word(1'b1, 2'd2), 1'b1);
    csb_read(misc_cfg_offset);
    // producer 1 and group 1 config
    csb_write(pointer_offset, 32'h1, 1'b1);
    csb_read(pointer_offset);
    csb_write(misc_cfg_offset, cfg_word(1'b0, 2'd1), 1'b1);
    csb_read(misc_cfg_offset);
    csb_write(pointer_offset, 32'h0, 1'b1);
    csb_read(misc_cfg_offset); // group 0 kept
    // launch both groups
    csb_write(op_enable_offset, 32'h1, 1'b1);
    csb_read(status_offset);
    wait_cycles(op_en_delay + 2);
    csb_write(pointer_offset, 32'h1, 1'b1);
    csb_write(op_enable_offset, 32'h1, 1'b1);
    csb_read(status_offset);
    csb_read(op_enable_offset);
    // first done hands over to group 1
    pulse_done();
    csb_read(pointer_offset);
    csb_read(status_offset);
    wait_cycles(op_en_delay + 2);
    // second done leaves all idle
    pulse_done();
    csb_read(pointer_offset);
    csb_read(status_offset);
    wait_cycles(op_en_delay + 2);
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period    = 20.0, // ns
  parameter int  rst_cycles = 2
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(period / 2.0) nvdla_core_clk = ~nvdla_core_clk;
  end

  // reset low for a few edges, released just after an edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (rst_cycles) @(posedge nvdla_core_clk);
    #2 nvdla_core_rstn = 1'b1;
  end

endmodule
